//--- include/gfx_cfg.svh
// Striped video source configuration
`ifndef GFX_CFG_SVH
`define GFX_CFG_SVH

// Bits per colour channel
`define GFX_COLOR_WIDTH 4

// Counter and line buffer address widths
`define GFX_COORD_WIDTH 8
`define GFX_COL_IDX_WIDTH 5

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduced 64x48 video timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define GFX_H_VISIBLE 64
`define GFX_H_FRONT 8
`define GFX_H_SYNC 16
`define GFX_H_BACK 16
`define GFX_H_TOTAL (`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK)

`define GFX_V_VISIBLE 48
`define GFX_V_FRONT 2
`define GFX_V_SYNC 2
`define GFX_V_BACK 4
`define GFX_V_TOTAL (`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK)

// Even and odd columns live in separate stripes
`define GFX_NUM_STRIPES 2

`endif

//--- design/gfx_pkg.sv
// Striped video source types
`include "gfx_cfg.svh"

package gfx_pkg;

  // One colour channel
  typedef logic [`GFX_COLOR_WIDTH-1:0] color_t;

  // Red, green and blue packed from high to low bits
  typedef logic [3*`GFX_COLOR_WIDTH-1:0] pixel_t;

  // Horizontal or vertical position
  typedef logic [`GFX_COORD_WIDTH-1:0] coord_t;

  // Entry address inside one half-width line buffer
  typedef logic [`GFX_COL_IDX_WIDTH-1:0] col_idx_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stripe fill sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // A stripe waits in idle, writes the next line in fill and
  // holds that line for display in ready
  typedef enum logic [1:0] {
    idle  = 2'd0,
    fill  = 2'd1,
    ready = 2'd2
  } fill_state_t;

endpackage

//--- design/vga_timing.sv
// VGA timing generator
`timescale 1ns/10ps
`include "gfx_cfg.svh"

module vga_timing (
  input  logic            pixel_clk,
  input  logic            reset,
  output gfx_pkg::coord_t x,
  output gfx_pkg::coord_t y,
  output logic            visible,
  output logic            line_start,
  output logic            frame_done,
  output logic            hsync_raw,
  output logic            vsync_raw
);
  import gfx_pkg::*;

  localparam coord_t H_LAST       = coord_t'(`GFX_H_TOTAL - 1);
  localparam coord_t V_LAST       = coord_t'(`GFX_V_TOTAL - 1);
  localparam coord_t H_VIS        = coord_t'(`GFX_H_VISIBLE);
  localparam coord_t V_VIS        = coord_t'(`GFX_V_VISIBLE);
  localparam coord_t H_SYNC_START = coord_t'(`GFX_H_VISIBLE + `GFX_H_FRONT);
  localparam coord_t H_SYNC_END   = coord_t'(`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC);
  localparam coord_t V_SYNC_START = coord_t'(`GFX_V_VISIBLE + `GFX_V_FRONT);
  localparam coord_t V_SYNC_END   = coord_t'(`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC);

  coord_t h_next;
  coord_t v_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next position
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    h_next = x + coord_t'(1);
    v_next = y;
    if (x == H_LAST) begin
      h_next = '0;
      if (y == V_LAST) begin
        v_next = '0;
      end else begin
        v_next = y + coord_t'(1);
      end
    end
  end

  // Every decode is taken from the next position so that all
  // outputs line up with the x and y registers
  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      x          <= '0;
      y          <= '0;
      visible    <= 1'b1;
      line_start <= 1'b0;
      frame_done <= 1'b0;
      hsync_raw  <= 1'b1;
      vsync_raw  <= 1'b1;
    end else begin
      x          <= h_next;
      y          <= v_next;
      visible    <= (h_next < H_VIS) && (v_next < V_VIS);
      line_start <= (h_next == H_VIS);
      frame_done <= (h_next == H_LAST) && (v_next == V_LAST);
      // Both syncs are active low
      hsync_raw  <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
      vsync_raw  <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
    end
  end

endmodule

//--- design/stripe_buffer.sv
// Stripe line buffer and fill sequencer
`timescale 1ns/10ps
`include "gfx_cfg.svh"

module stripe_buffer (
  input  logic            pixel_clk,
  input  logic            reset,
  input  logic            stripe_id,
  input  logic            continuous_write,
  input  gfx_pkg::coord_t x,
  input  gfx_pkg::coord_t y,
  input  logic            visible,
  input  logic            line_start,
  input  logic            frame_done,
  output gfx_pkg::pixel_t pixel,
  output logic            line_ready
);
  import gfx_pkg::*;

  localparam int       LINE_DEPTH = `GFX_H_VISIBLE / `GFX_NUM_STRIPES;
  localparam col_idx_t LAST_IDX   = col_idx_t'(LINE_DEPTH - 1);
  localparam coord_t   V_LAST     = coord_t'(`GFX_V_TOTAL - 1);

  pixel_t      line_mem [LINE_DEPTH];
  fill_state_t state;
  col_idx_t    fill_idx;
  coord_t      fill_line;
  coord_t      next_line;
  pixel_t      fill_pixel;
  col_idx_t    rd_idx;
  logic        rd_en;
  logic        last_read;
  logic        frame_filled;
  logic        frozen;

  // Line that follows the current one, wrapping after the last line
  assign next_line = (y == V_LAST) ? '0 : y + coord_t'(1);

  // Red carries the line, green the buffer index, blue the stripe
  assign fill_pixel = {fill_line[`GFX_COLOR_WIDTH-1:0],
                       fill_idx[`GFX_COLOR_WIDTH-1:0],
                       {`GFX_COLOR_WIDTH{stripe_id}}};

  // Column x belongs to stripe x mod 2 at index x/2
  assign rd_idx    = x[`GFX_COL_IDX_WIDTH:1];
  assign rd_en     = visible && (x[0] == stripe_id);
  assign last_read = rd_en && (rd_idx == LAST_IDX);

  // Once a whole frame has been written the old lines can be replayed
  assign frozen = frame_filled && !continuous_write;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge pixel_clk) begin
    if (state == fill) begin
      line_mem[fill_idx] <= fill_pixel;
    end
    if (rd_en) begin
      pixel <= line_mem[rd_idx];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fill sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      state        <= idle;
      fill_idx     <= '0;
      fill_line    <= '0;
      frame_filled <= 1'b0;
      line_ready   <= 1'b0;
    end else begin
      // Delayed by one cycle to match the read data
      line_ready <= (state == ready);

      if (frame_done) begin
        frame_filled <= 1'b1;
      end

      if (line_start) begin
        fill_idx <= '0;
        if (frozen) begin
          state <= ready;
        end else begin
          state     <= fill;
          fill_line <= next_line;
        end
      end else if (state == fill) begin
        fill_idx <= fill_idx + col_idx_t'(1);
        if (fill_idx == LAST_IDX) begin
          state <= ready;
        end
      end else if (state == ready && last_read && !frozen) begin
        state <= idle;
      end
    end
  end

endmodule

//--- design/stripe_merge.sv
// Stripe merge and output stage
`timescale 1ns/10ps

module stripe_merge (
  input  logic            pixel_clk,
  input  logic            reset,
  input  logic            x0,
  input  logic            visible,
  input  logic            hsync_raw,
  input  logic            vsync_raw,
  input  gfx_pkg::pixel_t pixel_even,
  input  logic            ready_even,
  input  gfx_pkg::pixel_t pixel_odd,
  input  logic            ready_odd,
  output gfx_pkg::color_t vga_red,
  output gfx_pkg::color_t vga_grn,
  output gfx_pkg::color_t vga_blu,
  output logic            vga_hsync,
  output logic            vga_vsync,
  output logic            vga_error
);
  import gfx_pkg::*;

  logic   x0_d1;
  logic   vis_d1;
  logic   hsync_d1;
  logic   vsync_d1;
  logic   armed;
  pixel_t sel_pixel;
  logic   sel_ready;
  logic   show;

  // Position info trails by one cycle to meet the stripe read data
  assign sel_pixel = x0_d1 ? pixel_odd : pixel_even;
  assign sel_ready = x0_d1 ? ready_odd : ready_even;
  assign show      = vis_d1 && sel_ready;

  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      x0_d1     <= 1'b0;
      vis_d1    <= 1'b0;
      hsync_d1  <= 1'b1;
      vsync_d1  <= 1'b1;
      armed     <= 1'b0;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_error <= 1'b0;
    end else begin
      x0_d1    <= x0;
      vis_d1   <= visible;
      hsync_d1 <= hsync_raw;
      vsync_d1 <= vsync_raw;

      // The line shown right after reset was never filled
      armed <= armed || ready_even || ready_odd;

      vga_red   <= show ? sel_pixel[3*$bits(color_t)-1:2*$bits(color_t)] : '0;
      vga_grn   <= show ? sel_pixel[2*$bits(color_t)-1:$bits(color_t)] : '0;
      vga_blu   <= show ? sel_pixel[$bits(color_t)-1:0] : '0;
      vga_hsync <= hsync_d1;
      vga_vsync <= vsync_d1;
      vga_error <= armed && vis_d1 && !sel_ready;
    end
  end

endmodule

//--- design/gfx_striped_top.sv
// Striped test pattern source
`timescale 1ns/10ps

module gfx_striped_top (
  input  logic            pixel_clk,
  input  logic            reset,
  input  logic            continuous_write,
  output gfx_pkg::color_t vga_red,
  output gfx_pkg::color_t vga_grn,
  output gfx_pkg::color_t vga_blu,
  output logic            vga_hsync,
  output logic            vga_vsync,
  output logic            vga_error
);
  import gfx_pkg::*;

  coord_t x;
  coord_t y;
  logic   visible;
  logic   line_start;
  logic   frame_done;
  logic   hsync_raw;
  logic   vsync_raw;
  pixel_t pixel_even;
  pixel_t pixel_odd;
  logic   ready_even;
  logic   ready_odd;

  vga_timing u_timing (
    .pixel_clk  (pixel_clk),
    .reset      (reset),
    .x          (x),
    .y          (y),
    .visible    (visible),
    .line_start (line_start),
    .frame_done (frame_done),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Even and odd column stripes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  stripe_buffer u_stripe_even (
    .pixel_clk        (pixel_clk),
    .reset            (reset),
    .stripe_id        (1'b0),
    .continuous_write (continuous_write),
    .x                (x),
    .y                (y),
    .visible          (visible),
    .line_start       (line_start),
    .frame_done       (frame_done),
    .pixel            (pixel_even),
    .line_ready       (ready_even)
  );

  stripe_buffer u_stripe_odd (
    .pixel_clk        (pixel_clk),
    .reset            (reset),
    .stripe_id        (1'b1),
    .continuous_write (continuous_write),
    .x                (x),
    .y                (y),
    .visible          (visible),
    .line_start       (line_start),
    .frame_done       (frame_done),
    .pixel            (pixel_odd),
    .line_ready       (ready_odd)
  );

  stripe_merge u_merge (
    .pixel_clk  (pixel_clk),
    .reset      (reset),
    .x0         (x[0]),
    .visible    (visible),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .pixel_even (pixel_even),
    .ready_even (ready_even),
    .pixel_odd  (pixel_odd),
    .ready_odd  (ready_odd),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_error  (vga_error)
  );

endmodule

//--- tests/gfx_striped_assertions.sv
// Output timing and pattern checker
`timescale 1ns/10ps
`include "gfx_cfg.svh"

module gfx_striped_assertions (
  input logic            pixel_clk,
  input logic            reset,
  input logic            continuous_write,
  input gfx_pkg::color_t vga_red,
  input gfx_pkg::color_t vga_grn,
  input gfx_pkg::color_t vga_blu,
  input logic            vga_hsync,
  input logic            vga_vsync,
  input logic            vga_error
);
  import gfx_pkg::*;

  localparam coord_t H_LAST  = coord_t'(`GFX_H_TOTAL - 1);
  localparam coord_t V_LAST  = coord_t'(`GFX_V_TOTAL - 1);
  localparam coord_t H_VIS   = coord_t'(`GFX_H_VISIBLE);
  localparam coord_t V_VIS   = coord_t'(`GFX_V_VISIBLE);
  localparam coord_t HS_BEG  = coord_t'(`GFX_H_VISIBLE + `GFX_H_FRONT);
  localparam coord_t HS_END  = coord_t'(`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC);
  localparam coord_t VS_BEG  = coord_t'(`GFX_V_VISIBLE + `GFX_V_FRONT);
  localparam coord_t VS_END  = coord_t'(`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC);

  int     error_count = 0;
  logic   hs_prev;
  logic   vs_prev;
  logic   h_lock;
  logic   v_lock;
  logic   h_lock_cur;
  logic   v_lock_cur;
  logic   frame_seen;
  logic   line_valid;
  logic   cw_d1;
  logic   cw_d2;
  logic   in_view;
  logic   exp_hsync;
  logic   exp_vsync;
  coord_t h_reg;
  coord_t v_reg;
  coord_t h_inc;
  coord_t v_inc;
  coord_t h_cur;
  coord_t v_cur;
  coord_t fill_line;
  color_t exp_red;
  color_t exp_grn;
  color_t exp_blu;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Position rebuilt from the syncs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // The first falling edge of each sync pins the counter, after
  // that the counters run free so a late or early edge is caught
  always_comb begin
    h_inc = (h_reg == H_LAST) ? '0 : h_reg + coord_t'(1);
    v_inc = v_reg;
    if (h_reg == H_LAST) begin
      v_inc = (v_reg == V_LAST) ? '0 : v_reg + coord_t'(1);
    end
    h_lock_cur = h_lock || (hs_prev && !vga_hsync);
    v_lock_cur = v_lock || (vs_prev && !vga_vsync);
    h_cur      = h_lock ? h_inc : HS_BEG;
    v_cur      = v_lock ? v_inc : VS_BEG;
  end

  assign in_view   = (h_cur < H_VIS) && (v_cur < V_VIS);
  assign exp_hsync = !((h_cur >= HS_BEG) && (h_cur < HS_END));
  assign exp_vsync = !((v_cur >= VS_BEG) && (v_cur < VS_END));
  assign exp_red   = in_view ? fill_line[`GFX_COLOR_WIDTH-1:0] : '0;
  assign exp_grn   = in_view ? h_cur[`GFX_COLOR_WIDTH:1] : '0;
  assign exp_blu   = (in_view && h_cur[0]) ? '1 : '0;

  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      hs_prev    <= 1'b1;
      vs_prev    <= 1'b1;
      h_lock     <= 1'b0;
      v_lock     <= 1'b0;
      frame_seen <= 1'b0;
      line_valid <= 1'b0;
      cw_d1      <= 1'b0;
      cw_d2      <= 1'b0;
      h_reg      <= '0;
      v_reg      <= '0;
      fill_line  <= '0;
    end else begin
      hs_prev <= vga_hsync;
      vs_prev <= vga_vsync;
      h_lock  <= h_lock_cur;
      v_lock  <= v_lock_cur;
      h_reg   <= h_cur;
      v_reg   <= v_cur;
      // The mode is sampled by the buffers two cycles before the output
      cw_d1   <= continuous_write;
      cw_d2   <= cw_d1;
      if (v_lock_cur && h_cur == H_LAST && v_cur == V_LAST) begin
        frame_seen <= 1'b1;
      end
      // Blanking start loads the next line unless the buffers are frozen
      if (v_lock_cur && h_cur == H_VIS && !(frame_seen && !cw_d2)) begin
        fill_line  <= (v_cur == V_LAST) ? '0 : v_cur + coord_t'(1);
        line_valid <= 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_quiet: assert property (@(posedge pixel_clk) disable iff (reset)
    !h_lock_cur |-> vga_vsync && vga_red == '0 && vga_grn == '0 && vga_blu == '0)
    else begin
      error_count++;
      $error("[FAIL] %0t idle outputs expected vsync 1 rgb 000 actual vsync %0b rgb %0h%0h%0h",
             $time, $sampled(vga_vsync), $sampled(vga_red), $sampled(vga_grn),
             $sampled(vga_blu));
    end

  a_hsync: assert property (@(posedge pixel_clk) disable iff (reset)
    h_lock_cur |-> vga_hsync == exp_hsync)
    else begin
      error_count++;
      $error("[FAIL] %0t vga_hsync expected %0b actual %0b", $time,
             $sampled(exp_hsync), $sampled(vga_hsync));
    end

  a_vsync: assert property (@(posedge pixel_clk) disable iff (reset)
    v_lock_cur |-> vga_vsync == exp_vsync)
    else begin
      error_count++;
      $error("[FAIL] %0t vga_vsync expected %0b actual %0b", $time,
             $sampled(exp_vsync), $sampled(vga_vsync));
    end

  a_red: assert property (@(posedge pixel_clk) disable iff (reset)
    v_lock_cur && line_valid |-> vga_red == exp_red)
    else begin
      error_count++;
      $error("[FAIL] %0t vga_red expected %0h actual %0h", $time,
             $sampled(exp_red), $sampled(vga_red));
    end

  a_grn: assert property (@(posedge pixel_clk) disable iff (reset)
    v_lock_cur && line_valid |-> vga_grn == exp_grn)
    else begin
      error_count++;
      $error("[FAIL] %0t vga_grn expected %0h actual %0h", $time,
             $sampled(exp_grn), $sampled(vga_grn));
    end

  a_blu: assert property (@(posedge pixel_clk) disable iff (reset)
    v_lock_cur && line_valid |-> vga_blu == exp_blu)
    else begin
      error_count++;
      $error("[FAIL] %0t vga_blu expected %0h actual %0h", $time,
             $sampled(exp_blu), $sampled(vga_blu));
    end

  // Errors are masked inside the DUT until the first fill
  a_error: assert property (@(posedge pixel_clk) disable iff (reset)
    !vga_error)
    else begin
      error_count++;
      $error("[FAIL] %0t vga_error expected 0 actual 1", $time);
    end

endmodule

//--- tests/gfx_striped_tb.sv
// Striped video source testbench
`timescale 1ns/10ps
`include "gfx_cfg.svh"

module gfx_striped_tb;
  import gfx_pkg::*;

  localparam int FRAME_CYCLES  = `GFX_H_TOTAL * `GFX_V_TOTAL;
  localparam int VSYNC_TIMEOUT = 2 * FRAME_CYCLES;

  logic   pixel_clk;
  logic   reset;
  logic   continuous_write;
  color_t vga_red;
  color_t vga_grn;
  color_t vga_blu;
  logic   vga_hsync;
  logic   vga_vsync;
  logic   vga_error;

  gfx_striped_top u_gfx_striped_top (
    .pixel_clk        (pixel_clk),
    .reset            (reset),
    .continuous_write (continuous_write),
    .vga_red          (vga_red),
    .vga_grn          (vga_grn),
    .vga_blu          (vga_blu),
    .vga_hsync        (vga_hsync),
    .vga_vsync        (vga_vsync),
    .vga_error        (vga_error)
  );

  bind gfx_striped_top gfx_striped_assertions u_assertions (
    .pixel_clk        (pixel_clk),
    .reset            (reset),
    .continuous_write (continuous_write),
    .vga_red          (vga_red),
    .vga_grn          (vga_grn),
    .vga_blu          (vga_blu),
    .vga_hsync        (vga_hsync),
    .vga_vsync        (vga_vsync),
    .vga_error        (vga_error)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #5 pixel_clk = ~pixel_clk;
  end

  // Stop the run as soon as the checker flags anything
  always @(negedge pixel_clk) begin
    if (u_gfx_striped_top.u_assertions.error_count != 0) begin
      $display("tests failed");
      $fatal(1, "assertion failure in the output checker");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame stepping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic wait_vsyncs(input int count);
    int   seen;
    int   cycles;
    logic prev;
    seen   = 0;
    cycles = 0;
    prev   = vga_vsync;
    while (seen < count) begin
      @(negedge pixel_clk);
      cycles++;
      if (prev && !vga_vsync) begin
        seen++;
        cycles = 0;
      end
      prev = vga_vsync;
      if (cycles > VSYNC_TIMEOUT) begin
        $display("no vsync pulse seen within %0d cycles", VSYNC_TIMEOUT);
        $display("tests failed");
        $fatal(1, "vsync timeout");
      end
    end
  endtask

  initial begin
    reset            = 1'b1;
    continuous_write = 1'b1;
    repeat (2) @(negedge pixel_clk);
    reset = 1'b0;

    // Live refill, then frozen buffers, then live again
    wait_vsyncs(3);
    continuous_write = 1'b0;
    wait_vsyncs(2);
    continuous_write = 1'b1;
    wait_vsyncs(1);
    @(negedge pixel_clk);

    if (u_gfx_striped_top.u_assertions.error_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "checker reported errors");
    end
  end

endmodule

//--- all.f
+incdir+include
design/gfx_pkg.sv
design/vga_timing.sv
design/stripe_buffer.sv
design/stripe_merge.sv
design/gfx_striped_top.sv
tests/gfx_striped_assertions.sv
tests/gfx_striped_tb.sv

//--- Bender.yml
package:
  name: gfx_striped

sources:
  - include_dirs:
      - include
    files:
      - design/gfx_pkg.sv
      - design/vga_timing.sv
      - design/stripe_buffer.sv
      - design/stripe_merge.sv
      - design/gfx_striped_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/gfx_striped_assertions.sv
      - tests/gfx_striped_tb.sv
